/* Makefile */
SIM      := verilator
TOP      := controller_active_tb
FILELIST := project.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* project.f */
rtl/i3c_bus_pkg.sv
rtl/controller_pkg.sv
rtl/fmt_if.sv
rtl/hci_queue.sv
rtl/flow_active.sv
rtl/i2c_controller_fsm.sv
rtl/controller_active.sv
testbench/controller_scoreboard.sv
testbench/controller_active_checker.sv
testbench/controller_active_tb.sv

/* rtl/controller_active.sv */
// Legacy I2C mode only with open-drain bus ports, so the wired-AND with targets is formed outside
`timescale 1ns/10ps
`default_nettype none

module controller_active
  import controller_pkg::*;
#(
  parameter int unsigned ClkDiv     = 4,
  parameter int unsigned QueueDepth = 4
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        cmd_valid_i,
  output logic        cmd_ready_o,
  input  logic [31:0] cmd_data_i,
  input  logic        tx_valid_i,
  output logic        tx_ready_o,
  input  logic [7:0]  tx_data_i,
  output logic        rx_valid_o,
  input  logic        rx_ready_i,
  output logic [7:0]  rx_data_o,
  output logic        resp_valid_o,
  input  logic        resp_ready_i,
  output logic [31:0] resp_data_o,
  input  logic        scl_i,
  input  logic        sda_i,
  output logic        scl_o,
  output logic        sda_o,
  output logic        idle_o
);

  cmd_desc_t  cmd_rdata;
  logic       cmd_rvalid;
  logic       cmd_rready;
  logic [7:0] tx_rdata;
  logic       tx_rvalid;
  logic       tx_rready;
  logic [7:0] rx_wdata;
  logic       rx_wvalid;
  logic       rx_wready;
  resp_desc_t resp_wdata;
  resp_desc_t resp_rdata;
  logic       resp_wvalid;
  logic       resp_wready;

  fmt_if fmt ();

  hci_queue #(.QueueDepth(QueueDepth), .payload_t(cmd_desc_t)) cmd_queue (
    .clk_i, .reset_i,
    .wvalid_i(cmd_valid_i), .wready_o(cmd_ready_o), .wdata_i(cmd_desc_t'(cmd_data_i)),
    .rvalid_o(cmd_rvalid), .rready_i(cmd_rready), .rdata_o(cmd_rdata)
  );

  hci_queue #(.QueueDepth(QueueDepth), .payload_t(logic [7:0])) tx_queue (
    .clk_i, .reset_i,
    .wvalid_i(tx_valid_i), .wready_o(tx_ready_o), .wdata_i(tx_data_i),
    .rvalid_o(tx_rvalid), .rready_i(tx_rready), .rdata_o(tx_rdata)
  );

  hci_queue #(.QueueDepth(QueueDepth), .payload_t(logic [7:0])) rx_queue (
    .clk_i, .reset_i,
    .wvalid_i(rx_wvalid), .wready_o(rx_wready), .wdata_i(rx_wdata),
    .rvalid_o(rx_valid_o), .rready_i(rx_ready_i), .rdata_o(rx_data_o)
  );

  hci_queue #(.QueueDepth(QueueDepth), .payload_t(resp_desc_t)) resp_queue (
    .clk_i, .reset_i,
    .wvalid_i(resp_wvalid), .wready_o(resp_wready), .wdata_i(resp_wdata),
    .rvalid_o(resp_valid_o), .rready_i(resp_ready_i), .rdata_o(resp_rdata)
  );

  assign resp_data_o = resp_rdata;

  flow_active flow_fsm (
    .clk_i, .reset_i,
    .cmd_rvalid_i(cmd_rvalid), .cmd_rdata_i(cmd_rdata), .cmd_rready_o(cmd_rready),
    .tx_rvalid_i(tx_rvalid), .tx_rdata_i(tx_rdata), .tx_rready_o(tx_rready),
    .rx_wvalid_o(rx_wvalid), .rx_wdata_o(rx_wdata), .rx_wready_i(rx_wready),
    .resp_wvalid_o(resp_wvalid), .resp_wdata_o(resp_wdata), .resp_wready_i(resp_wready),
    .fmt(fmt.flow),
    .idle_o
  );

  i2c_controller_fsm #(.ClkDiv(ClkDiv)) i2c_fsm (
    .clk_i, .reset_i,
    .scl_i, .sda_i, .scl_o, .sda_o,
    .fmt(fmt.engine)
  );

endmodule

`default_nettype wire

/* rtl/controller_pkg.sv */
// Command and response descriptors of the host queues, both 32 bits wide with the reserved bits on top
`default_nettype none

package controller_pkg;

  // Completion codes of a command
  typedef enum logic [1:0] {
    RESP_OK        = 2'd0,
    RESP_ADDR_NACK = 2'd1,
    RESP_DATA_NACK = 2'd2
  } resp_status_e;

  // A len of zero sends only the address phase
  typedef struct packed {
    logic [7:0] reserved;
    logic [7:0] tid;
    logic [7:0] len;
    logic       rnw;
    logic [6:0] addr;
  } cmd_desc_t;

  // count holds the data bytes acknowledged or read
  typedef struct packed {
    logic [13:0]  reserved;
    resp_status_e status;
    logic [7:0]   count;
    logic [7:0]   tid;
  } resp_desc_t;

endpackage

`default_nettype wire

/* rtl/flow_active.sv */
// Runs one command at a time and still pops the TX bytes of a NACKed write, so the host must push them
`timescale 1ns/10ps
`default_nettype none

module flow_active
  import controller_pkg::*;
  import i3c_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cmd_rvalid_i,
  input  cmd_desc_t  cmd_rdata_i,
  output logic       cmd_rready_o,
  input  logic       tx_rvalid_i,
  input  logic [7:0] tx_rdata_i,
  output logic       tx_rready_o,
  output logic       rx_wvalid_o,
  output logic [7:0] rx_wdata_o,
  input  logic       rx_wready_i,
  output logic       resp_wvalid_o,
  output resp_desc_t resp_wdata_o,
  input  logic       resp_wready_i,
  fmt_if.flow        fmt,
  output logic       idle_o
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_ADDR,
    S_ADDR_WAIT,
    S_DATA,
    S_DATA_WAIT,
    S_RX_PUSH,
    S_STOP,
    S_STOP_WAIT,
    S_DISCARD,
    S_RESP
  } state_e;

  state_e       state_q;
  cmd_desc_t    cmd_q;
  resp_status_e status_q;
  // Bytes acknowledged or read so far
  logic [7:0]   done_q;
  // TX bytes still to drop after a NACK
  logic [7:0]   remain_q;
  logic [7:0]   rx_byte_q;
  logic         last_byte;

  assign last_byte     = (done_q + 8'd1 == cmd_q.len);
  assign idle_o        = (state_q == S_IDLE);
  assign rx_wvalid_o   = (state_q == S_RX_PUSH);
  assign rx_wdata_o    = rx_byte_q;
  assign resp_wvalid_o = (state_q == S_RESP);

  always_comb begin
    resp_wdata_o        = '0;
    resp_wdata_o.tid    = cmd_q.tid;
    resp_wdata_o.count  = done_q;
    resp_wdata_o.status = status_q;
  end

  // Entry mux and queue pops
  always_comb begin
    fmt.entry_valid = 1'b0;
    fmt.entry       = '0;
    cmd_rready_o    = 1'b0;
    tx_rready_o     = 1'b0;
    case (state_q)
      // Hold new commands while the response queue has no room
      S_IDLE: cmd_rready_o = resp_wready_i;
      S_ADDR: begin
        fmt.entry_valid        = 1'b1;
        fmt.entry.start_before = 1'b1;
        fmt.entry.stop_after   = (cmd_q.len == 8'd0);
        fmt.entry.byte_data    = {cmd_q.addr, cmd_q.rnw};
      end
      S_DATA: begin
        fmt.entry.stop_after = last_byte;
        if (cmd_q.rnw) begin
          // A full RX queue leaves the engine idle with SCL low
          fmt.entry_valid     = rx_wready_i;
          fmt.entry.read      = 1'b1;
          fmt.entry.ack_last  = last_byte;
          fmt.entry.byte_data = 8'hFF;
        end else begin
          // An empty TX queue leaves the engine idle with SCL low
          fmt.entry_valid     = tx_rvalid_i;
          fmt.entry.byte_data = tx_rdata_i;
          tx_rready_o         = fmt.entry_ready;
        end
      end
      S_STOP: begin
        fmt.entry_valid      = 1'b1;
        fmt.entry.stop_only  = 1'b1;
        fmt.entry.stop_after = 1'b1;
      end
      S_DISCARD: tx_rready_o = (remain_q != 8'd0);
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= S_IDLE;
      status_q <= RESP_OK;
      done_q   <= '0;
      remain_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (cmd_rvalid_i && cmd_rready_o) begin
            state_q  <= S_ADDR;
            status_q <= RESP_OK;
            done_q   <= '0;
          end
        end
        S_ADDR: begin
          if (fmt.entry_ready) begin
            state_q <= S_ADDR_WAIT;
          end
        end
        S_ADDR_WAIT: begin
          if (fmt.result_valid) begin
            if (!fmt.result.ack) begin
              status_q <= RESP_ADDR_NACK;
              remain_q <= cmd_q.rnw ? 8'd0 : cmd_q.len;
              // An address-only command has its stop on the bus already
              state_q  <= (cmd_q.len == 8'd0) ? S_RESP : S_STOP;
            end else begin
              state_q <= (cmd_q.len == 8'd0) ? S_RESP : S_DATA;
            end
          end
        end
        S_DATA: begin
          if (fmt.entry_valid && fmt.entry_ready) begin
            state_q <= S_DATA_WAIT;
          end
        end
        S_DATA_WAIT: begin
          if (fmt.result_valid) begin
            if (cmd_q.rnw) begin
              done_q  <= done_q + 8'd1;
              state_q <= S_RX_PUSH;
            end else if (fmt.result.ack) begin
              done_q  <= done_q + 8'd1;
              state_q <= last_byte ? S_RESP : S_DATA;
            end else begin
              status_q <= RESP_DATA_NACK;
              remain_q <= cmd_q.len - done_q - 8'd1;
              state_q  <= last_byte ? S_RESP : S_STOP;
            end
          end
        end
        S_RX_PUSH: begin
          if (rx_wready_i) begin
            state_q <= (done_q == cmd_q.len) ? S_RESP : S_DATA;
          end
        end
        S_STOP: begin
          if (fmt.entry_ready) begin
            state_q <= S_STOP_WAIT;
          end
        end
        S_STOP_WAIT: begin
          if (fmt.result_valid) begin
            state_q <= S_DISCARD;
          end
        end
        S_DISCARD: begin
          if (remain_q == 8'd0) begin
            state_q <= S_RESP;
          end else if (tx_rvalid_i) begin
            remain_q <= remain_q - 8'd1;
          end
        end
        S_RESP: begin
          if (resp_wready_i) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Command and read byte holding registers
  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && cmd_rvalid_i && cmd_rready_o) begin
      cmd_q <= cmd_rdata_i;
    end
    if (state_q == S_DATA_WAIT && fmt.result_valid) begin
      rx_byte_q <= fmt.result.rx_byte;
    end
  end

endmodule

`default_nettype wire

/* rtl/fmt_if.sv */
// Allows one entry in flight and gives no back-pressure on result_valid, a single-cycle pulse
`timescale 1ns/10ps
`default_nettype none

interface fmt_if
  import i3c_bus_pkg::*;
();

  logic        entry_valid;
  logic        entry_ready;
  fmt_entry_t  entry;
  logic        result_valid;
  fmt_result_t result;

  modport flow (
    output entry_valid,
    output entry,
    input  entry_ready,
    input  result_valid,
    input  result
  );

  modport engine (
    input  entry_valid,
    input  entry,
    output entry_ready,
    output result_valid,
    output result
  );

endinterface

`default_nettype wire

/* rtl/hci_queue.sv */
// QueueDepth must be a power of two of at least 2 and wready_o stays low for one cycle after reset
`timescale 1ns/10ps
`default_nettype none

module hci_queue #(
  parameter int unsigned QueueDepth = 4,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     wvalid_i,
  output logic     wready_o,
  input  payload_t wdata_i,
  output logic     rvalid_o,
  input  logic     rready_i,
  output payload_t rdata_o
);

  localparam int unsigned PtrWidth = $clog2(QueueDepth);
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  payload_t            mem_q [QueueDepth];
  logic [PtrWidth-1:0] wptr_q;
  logic [PtrWidth-1:0] rptr_q;
  logic [CntWidth-1:0] count_q;
  logic [CntWidth-1:0] count_next;
  logic                open_q;
  logic                push;
  logic                pop;

  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rptr_q];
  assign pop      = rvalid_o & rready_i;
  // Room left, or the head leaves in this same cycle
  assign wready_o = open_q | pop;
  assign push     = wvalid_i & wready_o;

  always_comb begin
    count_next = count_q;
    if (push && !pop) begin
      count_next = count_q + 1'b1;
    end else if (pop && !push) begin
      count_next = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
      open_q  <= 1'b0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      count_q <= count_next;
      open_q  <= (count_next != CntWidth'(QueueDepth));
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/i2c_controller_fsm.sv */
// Open-drain outputs where 1 releases, with no arbitration, no repeated start and ClkDiv of 2 or more
`timescale 1ns/10ps
`default_nettype none

module i2c_controller_fsm
  import i3c_bus_pkg::*;
#(
  parameter int unsigned ClkDiv = 4
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  scl_i,
  input  logic  sda_i,
  output logic  scl_o,
  output logic  sda_o,
  fmt_if.engine fmt
);

  localparam int unsigned DivWidth = $clog2(ClkDiv);

  typedef enum logic [2:0] {
    E_IDLE,
    E_START,
    E_BIT,
    E_ACK,
    E_STOP
  } estate_e;

  estate_e             state_q;
  logic [DivWidth-1:0] div_q;
  logic [1:0]          qtr_q;
  logic [2:0]          bit_q;
  // SCL kept low between bytes of one transfer
  logic                held_q;
  logic                result_valid_q;
  fmt_entry_t          entry_q;
  logic [7:0]          shift_q;
  logic                sample_q;
  logic                ack_q;
  logic                wait_scl;
  logic                tick;
  logic                phase_end;

  // Wait for the bus to show SCL high before the sample point
  assign wait_scl  = scl_o & ~scl_i & (qtr_q == 2'd1);
  assign tick      = (div_q == DivWidth'(ClkDiv - 1)) & ~wait_scl;
  assign phase_end = tick & (qtr_q == 2'd3);

  assign fmt.entry_ready  = (state_q == E_IDLE);
  assign fmt.result_valid = result_valid_q;
  assign fmt.result       = '{ack: ack_q, rx_byte: shift_q};

  // Quarter 0 low, 1 and 2 high, 3 low for each bit
  always_comb begin
    scl_o = 1'b1;
    sda_o = 1'b1;
    case (state_q)
      E_IDLE: scl_o = ~held_q;
      E_START: begin
        // SDA falls while SCL is high
        scl_o = (qtr_q != 2'd3);
        sda_o = (qtr_q == 2'd0);
      end
      E_BIT: begin
        scl_o = (qtr_q == 2'd1) || (qtr_q == 2'd2);
        sda_o = entry_q.read | shift_q[7];
      end
      E_ACK: begin
        scl_o = (qtr_q == 2'd1) || (qtr_q == 2'd2);
        sda_o = entry_q.read ? entry_q.ack_last : 1'b1;
      end
      E_STOP: begin
        // SDA rises while SCL is high
        scl_o = (qtr_q != 2'd0);
        sda_o = (qtr_q[1] == 1'b1);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q        <= E_IDLE;
      div_q          <= '0;
      qtr_q          <= '0;
      bit_q          <= '0;
      held_q         <= 1'b0;
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= 1'b0;
      if (state_q == E_IDLE) begin
        div_q <= '0;
        qtr_q <= '0;
      end else if (tick) begin
        div_q <= '0;
        qtr_q <= qtr_q + 2'd1;
      end else if (!wait_scl) begin
        div_q <= div_q + 1'b1;
      end
      case (state_q)
        E_IDLE: begin
          bit_q <= '0;
          if (fmt.entry_valid) begin
            if (fmt.entry.stop_only) begin
              state_q <= E_STOP;
            end else if (fmt.entry.start_before) begin
              state_q <= E_START;
            end else begin
              state_q <= E_BIT;
            end
          end
        end
        E_START: begin
          if (phase_end) begin
            state_q <= E_BIT;
          end
        end
        E_BIT: begin
          if (phase_end) begin
            bit_q <= bit_q + 3'd1;
            if (bit_q == 3'd7) begin
              state_q <= E_ACK;
            end
          end
        end
        E_ACK: begin
          if (phase_end) begin
            if (entry_q.stop_after) begin
              state_q <= E_STOP;
            end else begin
              state_q        <= E_IDLE;
              held_q         <= 1'b1;
              result_valid_q <= 1'b1;
            end
          end
        end
        E_STOP: begin
          if (phase_end) begin
            state_q        <= E_IDLE;
            held_q         <= 1'b0;
            result_valid_q <= 1'b1;
          end
        end
        default: state_q <= E_IDLE;
      endcase
    end
  end

  // Byte shifter doubles as receiver since written bits are read back from the bus
  always_ff @(posedge clk_i) begin
    if (state_q == E_IDLE && fmt.entry_valid) begin
      entry_q <= fmt.entry;
      shift_q <= fmt.entry.byte_data;
    end
    if (tick && qtr_q == 2'd1) begin
      sample_q <= sda_i;
    end
    if (state_q == E_BIT && phase_end) begin
      shift_q <= {shift_q[6:0], sample_q};
    end
    if (state_q == E_ACK && phase_end) begin
      ack_q <= ~sample_q;
    end
  end

endmodule

`default_nettype wire

/* rtl/i3c_bus_pkg.sv */
// Format entry and result types shared by the flow FSM and the bit engine of the legacy I2C bus
`default_nettype none

package i3c_bus_pkg;

  // One byte on the bus, or a bare stop when stop_only is set
  typedef struct packed {
    logic       stop_only;
    logic       ack_last;
    logic       read;
    logic       stop_after;
    logic       start_before;
    logic [7:0] byte_data;
  } fmt_entry_t;

  // Returned once per entry
  typedef struct packed {
    // Valid only for written bytes
    logic       ack;
    logic [7:0] rx_byte;
  } fmt_result_t;

endpackage

`default_nettype wire

/* testbench/controller_active_checker.sv */
// Bound to controller_active, relies on engine start and stop states being encoded as 1 and 4
`timescale 1ns/10ps
`default_nettype none

module controller_active_checker
  import i3c_bus_pkg::*;
(
  input logic        clk_i,
  input logic        reset_i,
  input logic        entry_valid,
  input logic        entry_ready,
  input fmt_entry_t  entry,
  input logic        resp_valid_o,
  input logic        resp_ready_i,
  input logic [31:0] resp_data_o,
  input logic        scl_o,
  input logic        sda_o,
  input logic [2:0]  engine_state
);

  localparam logic [2:0] StartState = 3'd1;
  localparam logic [2:0] StopState  = 3'd4;

  entry_held: assert property (@(posedge clk_i) disable iff (reset_i)
    entry_valid && !entry_ready |=> entry_valid && $stable(entry))
    else $error("format entry dropped or changed before entry_ready");

  resp_held: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o))
    else $error("response dropped or changed before resp_ready_i");

  // SDA moves under SCL high only for start and stop
  sda_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    scl_o && $past(scl_o) && (sda_o != $past(sda_o)) |->
      (engine_state == StartState || engine_state == StopState))
    else $error("SDA changed while SCL was high");

endmodule

bind controller_active controller_active_checker checker_inst (
  .clk_i, .reset_i,
  .entry_valid(fmt.entry_valid), .entry_ready(fmt.entry_ready), .entry(fmt.entry),
  .resp_valid_o, .resp_ready_i, .resp_data_o,
  .scl_o, .sda_o,
  .engine_state(i2c_fsm.state_q)
);

`default_nettype wire

/* testbench/controller_active_tb.sv */
// Assumes ClkDiv 4 and a target at 7'h3A that NACKs written byte 5; the SCL is never stretched
`timescale 1ns/10ps
`default_nettype none

module controller_active_tb
  import controller_pkg::*;
();

  localparam int unsigned ClkDiv = 4;
  localparam int NumCmds = 10;

  logic        clk_i;
  logic        reset_i;
  logic        cmd_valid_i;
  logic        cmd_ready_o;
  logic [31:0] cmd_data_i;
  logic        tx_valid_i;
  logic        tx_ready_o;
  logic [7:0]  tx_data_i;
  logic        rx_valid_o;
  logic        rx_ready_i;
  logic [7:0]  rx_data_o;
  logic        resp_valid_o;
  logic        resp_ready_i;
  logic [31:0] resp_data_o;
  logic        scl_o;
  logic        sda_o;
  logic        idle_o;
  logic        scl_bus;
  logic        sda_bus;

  // Target model state
  logic        tgt_sda;
  logic        scl_q;
  logic        sda_q;
  logic        active;
  logic        addr_phase;
  logic        selected;
  logic        reading;
  logic        master_ack;
  logic [3:0]  bit_pos;
  logic [7:0]  shift;
  logic [7:0]  out_byte;
  int          byte_idx;
  logic        cap_valid;
  logic [7:0]  cap_data;

  logic [6:0]  cmd_addr [NumCmds];
  logic        cmd_rnw  [NumCmds];
  logic [7:0]  cmd_len  [NumCmds];
  int          seed;
  int          cycles;
  int          limit;
  int          tb_errors;
  int          sb_errors;
  int          resp_count;
  logic        final_check;

  // Wired-AND of controller and target
  assign scl_bus = scl_o;
  assign sda_bus = sda_o & tgt_sda;

  controller_active #(.ClkDiv(ClkDiv), .QueueDepth(4)) UUT (
    .clk_i, .reset_i,
    .cmd_valid_i, .cmd_ready_o, .cmd_data_i,
    .tx_valid_i, .tx_ready_o, .tx_data_i,
    .rx_valid_o, .rx_ready_i, .rx_data_o,
    .resp_valid_o, .resp_ready_i, .resp_data_o,
    .scl_i(scl_bus), .sda_i(sda_bus), .scl_o, .sda_o,
    .idle_o
  );

  controller_scoreboard scoreboard (
    .clk_i, .reset_i,
    .cmd_push_i(cmd_valid_i & cmd_ready_o), .cmd_data_i,
    .tx_push_i(tx_valid_i & tx_ready_o), .tx_data_i,
    .rx_pop_i(rx_valid_o & rx_ready_i), .rx_data_i(rx_data_o),
    .resp_pop_i(resp_valid_o & resp_ready_i), .resp_data_i(resp_data_o),
    .cap_valid_i(cap_valid), .cap_data_i(cap_data),
    .final_check_i(final_check),
    .errors_o(sb_errors), .resp_count_o(resp_count)
  );

  function automatic logic [7:0] read_byte(input int index);
    return 8'(index * 37 + 'h5A);
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // I2C target, sampled on the system clock
  always @(posedge clk_i) begin
    cap_valid <= 1'b0;
    scl_q     <= scl_bus;
    sda_q     <= sda_bus;
    if (reset_i) begin
      active  <= 1'b0;
      tgt_sda <= 1'b1;
    end else if (scl_bus && scl_q && sda_q && !sda_bus) begin
      active     <= 1'b1;
      addr_phase <= 1'b1;
      bit_pos    <= '0;
      byte_idx   <= 0;
      tgt_sda    <= 1'b1;
    end else if (scl_bus && scl_q && !sda_q && sda_bus) begin
      active  <= 1'b0;
      tgt_sda <= 1'b1;
    end else if (active && scl_bus && !scl_q) begin
      bit_pos <= bit_pos + 4'd1;
      if (bit_pos < 4'd8) begin
        shift <= {shift[6:0], sda_bus};
      end else begin
        master_ack <= !sda_bus;
      end
    end else if (active && !scl_bus && scl_q) begin
      if (bit_pos == 4'd8) begin
        if (addr_phase) begin
          selected <= (shift[7:1] == 7'h3A);
          reading  <= shift[0];
          tgt_sda  <= (shift[7:1] != 7'h3A);
        end else if (!reading && selected) begin
          cap_valid <= 1'b1;
          cap_data  <= shift;
          tgt_sda   <= (byte_idx == 5);
          byte_idx  <= byte_idx + 1;
        end else begin
          tgt_sda <= 1'b1;
        end
      end else if (bit_pos == 4'd9) begin
        bit_pos    <= '0;
        addr_phase <= 1'b0;
        if (selected && reading && (addr_phase || master_ack)) begin
          out_byte <= read_byte(byte_idx);
          tgt_sda  <= 1'(read_byte(byte_idx) >> 7);
          byte_idx <= byte_idx + 1;
        end else begin
          tgt_sda <= 1'b1;
        end
      end else if (selected && reading && !addr_phase) begin
        tgt_sda <= out_byte[4'd7 - bit_pos];
      end
    end
  end

  // Random stalls on the output queues
  initial begin
    rx_ready_i   = 1'b0;
    resp_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (!reset_i) begin
        rx_ready_i   = ($random(seed) % 4) != 0;
        resp_ready_i = ($random(seed) % 3) != 0;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles without all responses", cycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic push_command(input int idx);
    cmd_desc_t c;
    c      = '0;
    c.addr = cmd_addr[idx];
    c.rnw  = cmd_rnw[idx];
    c.len  = cmd_len[idx];
    c.tid  = 8'(idx + 1);
    @(negedge clk_i);
    cmd_valid_i = 1'b1;
    cmd_data_i  = c;
    // cmd_ready_o follows resp_ready_i when both queues are full
    @(posedge clk_i);
    while (!cmd_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic push_tx_byte();
    tx_valid_i = 1'b1;
    tx_data_i  = 8'($random(seed));
    while (!tx_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    tx_valid_i = 1'b0;
  endtask

  initial begin
    seed        = 32'h809a_4fec;
    cycles      = 0;
    limit       = 0;
    tb_errors   = 0;
    reset_i     = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_data_i  = '0;
    tx_valid_i  = 1'b0;
    tx_data_i   = '0;
    final_check = 1'b0;
    tgt_sda     = 1'b1;
    // Directed cases first, then a mixed batch
    cmd_addr = '{7'h3A, 7'h3A, 7'h11, 7'h3A, 7'h3A, 7'h3A, 7'h11, 7'h3A, 7'h3A, 7'h3A};
    cmd_rnw  = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
    cmd_len  = '{8'd4, 8'd5, 8'd3, 8'd8, 8'd2, 8'd0, 8'd3, 8'd6, 8'd1, 8'd2};
    for (int i = 0; i < NumCmds; i++) begin
      limit += (int'(cmd_len[i]) + 3) * 36 * ClkDiv;
    end
    limit = limit * 2;
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    for (int i = 0; i < NumCmds; i++) begin
      push_command(i);
      if (!cmd_rnw[i]) begin
        for (int j = 0; j < int'(cmd_len[i]); j++) begin
          push_tx_byte();
        end
      end
    end
    while (resp_count < NumCmds || rx_valid_o) @(negedge clk_i);
    if (!idle_o) begin
      $display("Controller not idle after the last response");
      tb_errors++;
    end
    final_check = 1'b1;
    @(negedge clk_i);
    final_check = 1'b0;
    @(negedge clk_i);
    $display("Errors: %0d in scoreboard, %0d in testbench", sb_errors, tb_errors);
    if (sb_errors == 0 && tb_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/controller_scoreboard.sv */
// Expects target 7'h3A to ACK, NACK written byte 5 and return index*37+8'h5A on reads
`timescale 1ns/10ps
`default_nettype none

module controller_scoreboard
  import controller_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        cmd_push_i,
  input  logic [31:0] cmd_data_i,
  input  logic        tx_push_i,
  input  logic [7:0]  tx_data_i,
  input  logic        rx_pop_i,
  input  logic [7:0]  rx_data_i,
  input  logic        resp_pop_i,
  input  logic [31:0] resp_data_i,
  input  logic        cap_valid_i,
  input  logic [7:0]  cap_data_i,
  input  logic        final_check_i,
  output int          errors_o,
  output int          resp_count_o
);

  cmd_desc_t  cmd_q [$];
  logic [7:0] tx_q [$];
  logic [7:0] cap_q [$];
  logic [7:0] rx_exp_q [$];
  int         errors = 0;
  int         resp_count = 0;

  assign errors_o     = errors;
  assign resp_count_o = resp_count;

  // Response the target rules lead to
  function automatic resp_desc_t expected_resp(input cmd_desc_t c);
    resp_desc_t r;
    r        = '0;
    r.tid    = c.tid;
    r.status = RESP_OK;
    r.count  = c.len;
    if (c.addr != 7'h3A) begin
      r.status = RESP_ADDR_NACK;
      r.count  = 8'd0;
    end else if (!c.rnw && c.len > 8'd5) begin
      r.status = RESP_DATA_NACK;
      r.count  = 8'd5;
    end
    return r;
  endfunction

  function automatic logic [7:0] expected_rx(input int index);
    return 8'(index * 37 + 'h5A);
  endfunction

  always @(posedge clk_i) begin
    cmd_desc_t  c;
    resp_desc_t exp;
    logic [7:0] b;
    logic [7:0] got;
    if (!reset_i) begin
      if (cap_valid_i) cap_q.push_back(cap_data_i);
      if (tx_push_i) tx_q.push_back(tx_data_i);
      if (cmd_push_i) begin
        c = cmd_desc_t'(cmd_data_i);
        cmd_q.push_back(c);
        if (c.rnw && c.addr == 7'h3A) begin
          for (int i = 0; i < int'(c.len); i++) rx_exp_q.push_back(expected_rx(i));
        end
      end
      if (rx_pop_i) begin
        if (rx_exp_q.size() == 0) begin
          $display("RX byte %h arrived with none expected", rx_data_i);
          errors++;
        end else begin
          b = rx_exp_q.pop_front();
          if (b !== rx_data_i) begin
            $display("[ERROR] rx byte: expected %h, actual %h", b, rx_data_i);
            errors++;
          end
        end
      end
      if (resp_pop_i) begin
        resp_count++;
        if (cmd_q.size() == 0) begin
          $display("Response %h arrived with no command pending", resp_data_i);
          errors++;
        end else begin
          c   = cmd_q.pop_front();
          exp = expected_resp(c);
          if (exp !== resp_desc_t'(resp_data_i)) begin
            $display("[ERROR] tid %0d response: expected %h, actual %h", c.tid, exp,
                     resp_data_i);
            errors++;
          end
          // Captured bytes stop after the NACKed byte
          for (int i = 0; i < int'(c.len) && !c.rnw; i++) begin
            if (tx_q.size() == 0) begin
              $display("TX bytes missing for command tid %0d", c.tid);
              errors++;
              break;
            end
            b = tx_q.pop_front();
            if (c.addr == 7'h3A && i <= 5) begin
              got = (cap_q.size() != 0) ? cap_q.pop_front() : 8'hxx;
              if (got !== b) begin
                $display("[ERROR] tid %0d write byte %0d: expected %h, actual %h", c.tid, i,
                         b, got);
                errors++;
              end
            end
          end
        end
      end
      if (final_check_i) begin
        if (cmd_q.size() != 0 || tx_q.size() != 0 || cap_q.size() != 0 ||
            rx_exp_q.size() != 0) begin
          $display("Data left over at the end of the run");
          errors++;
        end
      end
    end
  end

endmodule

`default_nettype wire
